//--- hw/gamePkg.sv
package gamePkg;

	typedef logic [8:0] pixelCoord; // screen coordinate, 320x240 field
	typedef logic [3:0] bcdDigit; // one decimal digit of the timer
	typedef logic [6:0] segPattern; // active low, segment a in bit 0

	typedef enum logic [1:0] {
		Rising,
		Falling,
		Resting
	} vertMode;

	localparam pixelCoord StepPx = 9'd4; // pixels per update on each axis
	localparam pixelCoord LeftTurn = 9'd3; // turn right at or below this x
	localparam pixelCoord RightTurn = 9'd300; // turn left at or above this x
	localparam pixelCoord GroundY = 9'd181; // start height and ground level
	localparam pixelCoord MaxJump = 9'd79; // jump height that ends rising
	localparam pixelCoord TopLimit = 9'd4; // rising ends above this y

	// y is the bottom left corner of the sprite, so ranges sit 40 px above the drawn ledge
	typedef struct packed {
		pixelCoord yLo;
		pixelCoord yHi;
		pixelCoord xLo;
		pixelCoord xHi;
	} platformRange;

	localparam int PlatformCount = 6;

	localparam platformRange Platforms [PlatformCount] = '{
		'{yLo: 9'd181, yHi: 9'd511, xLo: 9'd0, xHi: 9'd511}, // ground
		'{yLo: 9'd102, yHi: 9'd106, xLo: 9'd0, xHi: 9'd109}, // left middle
		'{yLo: 9'd102, yHi: 9'd106, xLo: 9'd191, xHi: 9'd301}, // right middle
		'{yLo: 9'd52, yHi: 9'd56, xLo: 9'd191, xHi: 9'd268}, // right top
		'{yLo: 9'd52, yHi: 9'd56, xLo: 9'd30, xHi: 9'd109}, // left top
		'{yLo: 9'd10, yHi: 9'd13, xLo: 9'd117, xHi: 9'd183} // top middle
	};

	localparam platformRange GoalRegion = '{yLo: 9'd10, yHi: 9'd13, xLo: 9'd133, xHi: 9'd187};

	function automatic logic inRegion(platformRange r, pixelCoord x, pixelCoord y);
		return (y >= r.yLo) && (y <= r.yHi) && (x >= r.xLo) && (x <= r.xHi);
	endfunction

	function automatic segPattern segOf(bcdDigit d);
		case (d)
			4'd0: return 7'b100_0000; // all but g
			4'd1: return 7'b111_1001;
			4'd2: return 7'b010_0100;
			4'd3: return 7'b011_0000;
			4'd4: return 7'b001_1001;
			4'd5: return 7'b001_0010;
			4'd6: return 7'b000_0010;
			4'd7: return 7'b111_1000;
			4'd8: return 7'b000_0000;
			4'd9: return 7'b001_1000;
			default: return 7'b111_1111; // blank for non-decimal codes
		endcase
	endfunction

endpackage

//--- hw/playerIf.sv
`timescale 1ns/1ps

interface playerIf;
	import gamePkg::*;

	pixelCoord xPos; // bottom left corner of the sprite
	pixelCoord yPos;
	logic onPlatform; // standing on ground or a ledge
	logic atGoal; // inside the winning region

	modport motion (
		output xPos,
		output yPos,
		input onPlatform
	);

	modport decode (
		input xPos,
		input yPos,
		output onPlatform,
		output atGoal
	);

	modport control (
		input atGoal
	);

endinterface

//--- hw/gameControl.sv
`timescale 1ns/1ps

module gameControl #(
	parameter int unsigned FrameTicks = 3255732
) (
	input logic clk,
	input logic reset,
	playerIf.control player,
	output logic update,
	output logic won
);
	localparam int unsigned CountW = $clog2(FrameTicks);
	localparam logic [CountW-1:0] LastTick = CountW'(FrameTicks - 1);

	typedef enum logic [1:0] {
		Waiting, // counting out the frame
		Checking, // position settled, look at goal flag
		Ended // game won, motion frozen
	} ctrlState;

	ctrlState state;
	logic [CountW-1:0] frameCount;
	logic frameEnd;

	assign frameEnd = (frameCount == LastTick);
	assign update = frameEnd && (state == Waiting); // one-cycle move strobe
	assign won = (state == Ended);

	always_ff @(posedge clk) begin
		if (reset) begin
			frameCount <= '0;
		end else if (frameEnd) begin
			frameCount <= '0; // wrap at end of frame
		end else begin
			frameCount <= frameCount + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= Waiting;
		end else begin
			case (state)
				Waiting: begin
					if (frameEnd) begin
						state <= Checking; // strobe goes out this cycle
					end
				end
				Checking: begin
					state <= player.atGoal ? Ended : Waiting; // new position is visible now
				end
				Ended: begin
					state <= Ended; // held until reset
				end
				default: begin
					state <= Waiting;
				end
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) !(update && won));

endmodule

//--- hw/platformDecode.sv
`timescale 1ns/1ps

module platformDecode (
	playerIf.decode player
);
	import gamePkg::*;

	logic supported; // any platform entry matches
	logic inGoal;

	always_comb begin
		supported = 1'b0;
		for (int i = 0; i < PlatformCount; i++) begin
			if (inRegion(Platforms[i], player.xPos, player.yPos)) begin
				supported = 1'b1;
			end
		end
		inGoal = inRegion(GoalRegion, player.xPos, player.yPos);
	end

	assign player.onPlatform = supported; // zero latency to motion
	assign player.atGoal = inGoal; // zero latency to control

endmodule

//--- hw/playerMotion.sv
`timescale 1ns/1ps

module playerMotion (
	input logic clk,
	input logic reset,
	input logic jump,
	input logic update,
	playerIf.motion player
);
	import gamePkg::*;

	logic goRight; // 1 moves x up, 0 moves x down
	vertMode mode;
	pixelCoord jumpHeight; // pixels risen in current jump

	logic rightNext;
	vertMode modeJump; // mode with this cycle's jump press applied
	vertMode modeNext; // mode used for the move on update

	always_comb begin
		modeJump = (jump && player.onPlatform) ? Rising : mode; // jump only with support

		rightNext = goRight;
		if (player.xPos <= LeftTurn) begin
			rightNext = 1'b1; // bounce off left edge
		end else if (player.xPos >= RightTurn) begin
			rightNext = 1'b0; // sprite is 20 wide, turn before right edge
		end

		if ((jumpHeight >= MaxJump) || (player.yPos < TopLimit)) begin
			modeNext = Falling; // top of the jump
		end else if (player.onPlatform && (modeJump != Rising)) begin
			modeNext = Resting; // landed, never stops mid jump
		end else if (modeJump != Rising) begin
			modeNext = Falling; // walked off a ledge
		end else begin
			modeNext = Rising;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			player.xPos <= '0;
			player.yPos <= GroundY;
			goRight <= 1'b1;
			mode <= Resting;
			jumpHeight <= '0;
		end else if (update) begin
			goRight <= rightNext;
			mode <= modeNext;
			if (rightNext) begin
				player.xPos <= player.xPos + StepPx;
			end else begin
				player.xPos <= player.xPos - StepPx;
			end
			case (modeNext)
				Rising: begin
					player.yPos <= player.yPos - StepPx; // y grows downward
					jumpHeight <= jumpHeight + StepPx;
				end
				Falling: begin
					player.yPos <= player.yPos + StepPx;
					jumpHeight <= '0; // fall distance is not tracked
				end
				default: begin
					player.yPos <= player.yPos; // resting on support
				end
			endcase
		end else begin
			mode <= modeJump; // press latched between frames
		end
	end

	assert property (@(posedge clk) disable iff (reset) player.xPos <= RightTurn + StepPx);

endmodule

//--- hw/elapsedTimer.sv
`timescale 1ns/1ps

module elapsedTimer #(
	parameter int unsigned TenthTicks = 5000000
) (
	input logic clk,
	input logic reset,
	input logic won,
	output gamePkg::segPattern hex0,
	output gamePkg::segPattern hex1,
	output gamePkg::segPattern hex2,
	output gamePkg::segPattern hex3,
	output gamePkg::segPattern hex4,
	output gamePkg::segPattern hex5
);
	import gamePkg::*;

	localparam int DigitCount = 6;
	localparam int unsigned DivW = $clog2(TenthTicks);
	localparam logic [DivW-1:0] LastCount = DivW'(TenthTicks - 1);

	logic [DivW-1:0] divCount;
	logic tick; // one tenth of a second elapsed
	bcdDigit digits [DigitCount]; // digit 0 is tenths
	logic [DigitCount-1:0] carry; // carry[i] advances digit i

	assign tick = !won && (divCount == LastCount);

	always_ff @(posedge clk) begin
		if (reset) begin
			divCount <= '0;
		end else if (!won) begin
			if (divCount == LastCount) begin
				divCount <= '0;
			end else begin
				divCount <= divCount + 1'b1;
			end
		end
	end

	always_comb begin
		carry[0] = tick;
		for (int i = 0; i < DigitCount - 1; i++) begin
			carry[i+1] = carry[i] && (digits[i] == 4'd9); // ripple on 9 to 0
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DigitCount; i++) begin
				digits[i] <= '0;
			end
		end else begin
			for (int i = 0; i < DigitCount; i++) begin
				if (carry[i]) begin
					digits[i] <= (digits[i] == 4'd9) ? 4'd0 : digits[i] + 4'd1;
				end
			end
		end
	end

	assign hex0 = segOf(digits[0]);
	assign hex1 = segOf(digits[1]);
	assign hex2 = segOf(digits[2]);
	assign hex3 = segOf(digits[3]);
	assign hex4 = segOf(digits[4]);
	assign hex5 = segOf(digits[5]);

	for (genvar g = 0; g < DigitCount; g++) begin : digitCheck
		assert property (@(posedge clk) disable iff (reset) digits[g] <= 4'd9);
	end

endmodule

//--- hw/gameTop.sv
`timescale 1ns/1ps

module gameTop #(
	parameter int unsigned FrameTicks = 3255732, // about 15 frames per second at 50 MHz
	parameter int unsigned TenthTicks = 5000000 // tenth of a second at 50 MHz
) (
	input logic clk,
	input logic reset,
	input logic jump,
	output gamePkg::pixelCoord xPos,
	output gamePkg::pixelCoord yPos,
	output logic won,
	output gamePkg::segPattern hex0,
	output gamePkg::segPattern hex1,
	output gamePkg::segPattern hex2,
	output gamePkg::segPattern hex3,
	output gamePkg::segPattern hex4,
	output gamePkg::segPattern hex5
);
	logic update; // frame strobe to motion

	playerIf player();

	gameControl #(.FrameTicks(FrameTicks)) ctrl (
		.clk(clk),
		.reset(reset),
		.player(player.control),
		.update(update),
		.won(won)
	);

	platformDecode decoder (
		.player(player.decode)
	);

	playerMotion mover (
		.clk(clk),
		.reset(reset),
		.jump(jump),
		.update(update),
		.player(player.motion)
	);

	elapsedTimer #(.TenthTicks(TenthTicks)) timer (
		.clk(clk),
		.reset(reset),
		.won(won), // stops the count
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5)
	);

	assign xPos = player.xPos;
	assign yPos = player.yPos;

endmodule

//--- verif/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int PeriodNs = 40,
	parameter int ResetCycles = 5
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PeriodNs / 2.0) clk = ~clk; // first rising edge at half a period
	end

	initial begin
		reset = 1'b1;
		repeat (ResetCycles) @(negedge clk); // covers ResetCycles rising edges
		reset = 1'b0; // dropped on a falling edge
	end

endmodule

//--- verif/gameTb.sv
`timescale 1ns/1ps

module gameTb;
	import gamePkg::*;

	localparam int ClockNs = 40;
	localparam int FrameTicks = 16; // short frames keep the run small
	localparam int TenthTicks = 40;
	localparam int MoveStep = 4;
	localparam int GroundLevel = 181;
	localparam int WalkFrames = 160; // one full sweep right and back
	localparam int JumpFrames = 45;
	localparam int TimerTarget = 321; // last timer checkpoint in tenths
	localparam int RandomFrames = 3000;
	localparam int FreezeFrames = 6;
	localparam int NoPress = 0;
	localparam int FirstPress = 1;
	localparam int RandomPress = 2;
	localparam longint TotalFrames = WalkFrames + JumpFrames + RandomFrames + FreezeFrames
		+ (TimerTarget * TenthTicks) / FrameTicks;
	localparam longint WatchdogNs = (TotalFrames + 100) * FrameTicks * ClockNs; // 100 frames spare

	// ledges only, the ground is any y at or below 181 on screen
	localparam int LedgeYLo [5] = '{102, 102, 52, 52, 10};
	localparam int LedgeYHi [5] = '{106, 106, 56, 56, 13};
	localparam int LedgeXLo [5] = '{0, 191, 191, 30, 117};
	localparam int LedgeXHi [5] = '{109, 301, 268, 109, 183};

	logic clk;
	logic reset;
	logic jump;
	pixelCoord xPos;
	pixelCoord yPos;
	logic won;
	segPattern hexOut [6];

	int mX, mY, jumpHt; // reference model of the player
	logic mRight, mWon, checkNext;
	vertMode mMode;
	int frameCnt, cycles, activeCycles;
	int checks, valueErrors, otherErrors;
	int seedValue;

	tbClock #(.PeriodNs(ClockNs), .ResetCycles(5)) clockGen (.clk(clk), .reset(reset));

	gameTop #(.FrameTicks(FrameTicks), .TenthTicks(TenthTicks)) DUT (
		.clk(clk),
		.reset(reset),
		.jump(jump),
		.xPos(xPos),
		.yPos(yPos),
		.won(won),
		.hex0(hexOut[0]),
		.hex1(hexOut[1]),
		.hex2(hexOut[2]),
		.hex3(hexOut[3]),
		.hex4(hexOut[4]),
		.hex5(hexOut[5])
	);

	function automatic logic supportAt(int x, int y);
		logic hit;
		hit = (y >= GroundLevel);
		for (int i = 0; i < 5; i++) begin
			if (y >= LedgeYLo[i] && y <= LedgeYHi[i] && x >= LedgeXLo[i] && x <= LedgeXHi[i]) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	function automatic logic goalAt(int x, int y);
		return (y >= 10) && (y <= 13) && (x >= 133) && (x <= 187);
	endfunction

	function automatic segPattern segExpected(int d);
		case (d)
			0: return 7'b1000000; // g dark
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			default: return 7'b0011000; // 9
		endcase
	endfunction

	task automatic checkCoord(input string name, input pixelCoord got, input pixelCoord exp);
		checks++;
		if (got !== exp) begin
			valueErrors++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkSeg(input string name, input segPattern got, input segPattern exp);
		checks++;
		if (got !== exp) begin
			valueErrors++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			valueErrors++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// all six digits against a count of tenths
	task automatic checkDigits(input int tenths);
		int divisor;
		divisor = 1;
		for (int i = 0; i < 6; i++) begin
			checkSeg($sformatf("hex%0d", i), hexOut[i], segExpected((tenths / divisor) % 10));
			divisor = divisor * 10;
		end
	endtask

	// one rising edge of the model, all decisions use pre-edge values
	task automatic modelEdge(input logic j, output bit moved);
		logic sup, upd, toRight;
		vertMode modeJ, modeN;
		sup = supportAt(mX, mY);
		upd = (frameCnt == FrameTicks - 1) && !mWon;
		modeJ = (j && sup) ? Rising : mMode; // press honored only with support
		if (!mWon) activeCycles++; // timer stops once won
		if (checkNext && goalAt(mX, mY)) mWon = 1'b1; // goal seen the cycle after a move
		checkNext = upd;
		frameCnt = (frameCnt == FrameTicks - 1) ? 0 : frameCnt + 1;
		cycles++;
		moved = upd;
		if (upd) begin
			toRight = mRight;
			if (mX <= 3) toRight = 1'b1;
			else if (mX >= 300) toRight = 1'b0;
			if (jumpHt >= 79 || mY < 4) modeN = Falling;
			else if (sup && modeJ != Rising) modeN = Resting;
			else if (modeJ != Rising) modeN = Falling;
			else modeN = Rising;
			mX = toRight ? mX + MoveStep : mX - MoveStep;
			if (modeN == Rising) begin
				mY = mY - MoveStep; // screen y grows downward
				jumpHt = jumpHt + MoveStep;
			end else if (modeN == Falling) begin
				mY = mY + MoveStep;
				jumpHt = 0;
			end
			mRight = toRight;
			mMode = modeN;
		end else begin
			mMode = modeJ;
		end
	endtask

	// called on a falling edge, returns on the next one
	task automatic step(input logic j, output bit moved);
		jump = j;
		@(posedge clk);
		modelEdge(j, moved);
		@(negedge clk);
		checkFlag("won", won, mWon);
		if (moved) begin
			checkCoord("xPos", xPos, pixelCoord'(mX));
			checkCoord("yPos", yPos, pixelCoord'(mY));
			checkDigits(activeCycles / TenthTicks);
		end
	endtask

	task automatic runFrame(input int press);
		bit moved, first;
		logic j;
		moved = 1'b0;
		first = 1'b1;
		while (!moved && !mWon) begin
			case (press)
				FirstPress: j = first;
				RandomPress: j = (($urandom % 32) == 0); // roughly one press per two frames
				default: j = 1'b0;
			endcase
			step(j, moved);
			first = 1'b0;
		end
	endtask

	task automatic checkReset();
		checkCoord("xPos", xPos, 9'd0);
		checkCoord("yPos", yPos, 9'd181);
		checkFlag("won", won, 1'b0);
		checkDigits(0);
	endtask

	task automatic walkAndTurn();
		bit seenRight, seenLeft;
		seenRight = 1'b0;
		seenLeft = 1'b0;
		for (int f = 0; f < WalkFrames; f++) begin
			runFrame(NoPress);
			checkCoord("yPos", yPos, 9'd181); // never leaves the ground
			if (xPos == 9'd300) seenRight = 1'b1;
			if (seenRight && xPos <= 9'd3) seenLeft = 1'b1;
		end
		if (!seenRight || !seenLeft) begin
			otherErrors++;
			$display("walk did not reach both turning points");
		end
	endtask

	task automatic jumpFromGround();
		int yStart;
		yStart = mY;
		runFrame(FirstPress);
		checkCoord("yPos", yPos, pixelCoord'(yStart - MoveStep)); // first frame rises
		for (int f = 1; f < JumpFrames; f++) begin
			runFrame(NoPress);
		end
	endtask

	task automatic timerCount();
		int targets [2];
		bit moved;
		targets = '{100, TimerTarget};
		foreach (targets[t]) begin
			while (cycles < targets[t] * TenthTicks) begin
				step(1'b0, moved);
			end
			checkFlag("won", won, 1'b0);
			checkDigits(targets[t]); // n tenths after n*TenthTicks cycles
		end
	endtask

	task automatic randomToGoal();
		bit moved;
		for (int f = 0; f < RandomFrames && !mWon; f++) begin
			runFrame(RandomPress);
		end
		if (!mWon) begin
			otherErrors++;
			$display("random play ended without reaching the goal");
		end else begin
			step(1'b0, moved); // won already compared on the win edge
			for (int c = 1; c <= FreezeFrames * FrameTicks; c++) begin
				step(($urandom % 4) == 0, moved);
				if (c % FrameTicks == 0) begin
					checkCoord("xPos", xPos, pixelCoord'(mX)); // model stops moving once won
					checkCoord("yPos", yPos, pixelCoord'(mY));
					checkDigits(activeCycles / TenthTicks);
				end
			end
		end
	endtask

	initial begin
		#(WatchdogNs);
		$display("watchdog expired, tests did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		jump = 1'b0;
		mX = 0;
		mY = GroundLevel;
		mRight = 1'b1;
		mMode = Resting;
		jumpHt = 0;
		mWon = 1'b0;
		checkNext = 1'b0;
		frameCnt = 0;
		cycles = 0;
		activeCycles = 0;
		checks = 0;
		valueErrors = 0;
		otherErrors = 0;
		seedValue = $urandom(32'hc10b);
		@(negedge reset); // lands on a falling edge
		checkReset();
		walkAndTurn();
		jumpFromGround();
		timerCount();
		randomToGoal();
		$display("checks: %0d, value errors: %0d, other errors: %0d",
			checks, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- all.f
hw/gamePkg.sv
hw/playerIf.sv
hw/gameControl.sv
hw/platformDecode.sv
hw/playerMotion.sv
hw/elapsedTimer.sv
hw/gameTop.sv
verif/tbClock.sv
verif/gameTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= gameTb
FLIST ?= all.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(OBJDIR)
